// File: list.f
+incdir+verilog
verilog/demodPkg.sv
verilog/demodRegs.sv
verilog/fmDiscriminator.sv
verilog/falseLockDetector.sv
verilog/dacMux.sv
verilog/demodBackEnd.sv
verif/demodBackEnd_tb.sv

// File: Makefile
# Verilator build and run of the demodulator back end testbench
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module demodBackEnd_tb -f list.f -o demodBackEnd_sim

run: compile
	./obj_dir/demodBackEnd_sim | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// File: verif/demodBackEnd_tb.sv
`include "demod_cfg.svh"
`default_nettype none

module demodBackEnd_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int sampleWidth  = `SAMPLE_WIDTH;
    localparam int clkPeriod    = 4;
    localparam int resetCycles  = 8;
    localparam int randomCycles = 400;
    localparam int phaseCycles  = 24;
    localparam int swapCycles   = 64;
    // per-test budgets including register setup, plus a margin
    localparam int totalCycles  = resetCycles + 40 + 60 + randomCycles + 40
                                  + 5 * phaseCycles + 40 + 2 * swapCycles + 200;

    logic                       clk;
    logic                       reset;
    logic [`BUS_ADDR_WIDTH-1:0] addr;
    logic [`BUS_DATA_WIDTH-1:0] din;
    logic                       wr0;
    logic                       wr1;
    logic                       wr2;
    logic                       wr3;
    logic                       ddcSync;
    demodPkg::iqSample          ddcSample;
    logic                       carrierLock;
    logic [`BUS_DATA_WIDTH-1:0] dout;
    logic                       highFreqOffset;
    demodPkg::dacChannel        dac0;
    demodPkg::dacChannel        dac1;
    demodPkg::dacChannel        dac2;

    // reference model state
    logic [`BUS_DATA_WIDTH-1:0]    modelControl;
    logic [`BUS_DATA_WIDTH-1:0]    modelLock;
    logic signed [sampleWidth-1:0] modelPrevI;
    logic signed [sampleWidth-1:0] modelPrevQ;
    logic signed [sampleWidth-1:0] modelSwapI;
    logic signed [sampleWidth-1:0] modelSwapQ;
    logic                          modelFmSync;
    logic signed [sampleWidth-1:0] modelFmVideo;
    logic signed [sampleWidth-1:0] modelLatched;
    logic        [sampleWidth-1:0] modelLatchedAbs;
    logic signed [sampleWidth-1:0] modelAvg;
    logic        [sampleWidth-1:0] modelAbsAvg;
    logic                          modelHfo;
    logic [sampleWidth:0]          modelDac0;
    logic [sampleWidth:0]          modelDac1;
    logic [sampleWidth:0]          modelDac2;
    logic [`BUS_DATA_WIDTH-1:0]    expectedDout;

    string       testName    = "resetState";
    int          errorCount  = 0;
    int          testErrors  = 0;
    int          testsRun    = 0;
    int          testsFailed = 0;
    logic [31:0] rngState    = 32'd86963;

    demodBackEnd DUT (
        .clk            (clk),
        .reset          (reset),
        .addr           (addr),
        .din            (din),
        .wr0            (wr0),
        .wr1            (wr1),
        .wr2            (wr2),
        .wr3            (wr3),
        .ddcSync        (ddcSync),
        .ddcSample      (ddcSample),
        .carrierLock    (carrierLock),
        .dout           (dout),
        .highFreqOffset (highFreqOffset),
        .dac0           (dac0),
        .dac1           (dac1),
        .dac2           (dac2)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] mixed;
        mixed = state ^ (state << 13);
        mixed = mixed ^ (mixed >> 17);
        mixed = mixed ^ (mixed << 5);
        return mixed;
    endfunction

    function automatic logic [`BUS_ADDR_WIDTH-1:0] regAddress(input logic [1:0] offset);
        return {`DEMOD_SPACE, offset, 2'b00};
    endfunction

    // old bytes kept wherever the strobe is low
    function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] strobes);
        logic [31:0] mask;
        mask = {{8{strobes[3]}}, {8{strobes[2]}}, {8{strobes[1]}}, {8{strobes[0]}}};
        return (old & ~mask) | (data & mask);
    endfunction

    function automatic logic [sampleWidth-1:0] crossProduct(input longint prevI,
        input longint prevQ, input longint nowI, input longint nowQ);
        longint diff;
        diff = (prevI * nowQ - prevQ * nowI) >>> `FRAC_BITS;
        return diff[sampleWidth-1:0];
    endfunction

    // alpha field is Q15, so 0x8000 weighs the new sample by exactly 1
    function automatic logic [sampleWidth-1:0] weightedAverage(input longint sample,
        input longint previous, input logic [15:0] alphaField);
        longint weight;
        longint total;
        weight = {alphaField, 2'b00};
        total  = ((sample * weight) >>> `FRAC_BITS)
                 + ((previous * ((longint'(1) << `FRAC_BITS) - weight)) >>> `FRAC_BITS);
        return total[sampleWidth-1:0];
    endfunction

    function automatic longint magnitudeOf(input longint value);
        return (value < 0) ? -value : value;
    endfunction

    // {sync, data} of one monitor channel, unknown codes act as raw I
    function automatic logic [sampleWidth:0] channelSource(input logic [3:0] sel,
                                                           input logic [sampleWidth-1:0] avgWord);
        if (sel == `DAC_Q) return {ddcSync, modelSwapQ};
        if (sel == `DAC_FREQ) return {modelFmSync, modelFmVideo};
        if (sel == `DAC_AVGFREQ) return {modelFmSync, avgWord};
        return {ddcSync, modelSwapI};
    endfunction

    function automatic logic [31:0] expectedRead(input logic [`BUS_ADDR_WIDTH-1:0] address,
        input logic [31:0] ctrl, input logic [31:0] lock, input logic locked, input logic hfo);
        logic [31:0] status;
        status = '0;
        status[`STATUS_HFO_BIT]  = hfo;
        status[`STATUS_LOCK_BIT] = locked;
        if (address[`BUS_ADDR_WIDTH-1:`SPACE_LSB] != `DEMOD_SPACE) return '0;
        case (address[`OFFSET_MSB:`OFFSET_LSB])
            `REG_CONTROL: return ctrl;
            `REG_LOCK:    return lock;
            `REG_STATUS:  return status;
            default:      return '0;
        endcase
    endfunction

    assign expectedDout = expectedRead(addr, modelControl, modelLock, carrierLock, modelHfo);

    always @(posedge clk) begin
        if (reset) begin
            modelControl    <= '0;
            modelLock       <= '0;
            modelPrevI      <= '0;
            modelPrevQ      <= '0;
            modelSwapI      <= '0;
            modelSwapQ      <= '0;
            modelFmSync     <= 1'b0;
            modelFmVideo    <= '0;
            modelLatched    <= '0;
            modelLatchedAbs <= '0;
            modelAvg        <= '0;
            modelAbsAvg     <= '0;
            modelHfo        <= 1'b0;
            modelDac0       <= '0;
            modelDac1       <= '0;
            modelDac2       <= '0;
        end else begin
            if (addr == regAddress(`REG_CONTROL))
                modelControl <= mergeBytes(modelControl, din, {wr3, wr2, wr1, wr0});
            if (addr == regAddress(`REG_LOCK))
                modelLock <= mergeBytes(modelLock, din, {wr3, wr2, wr1, wr0});
            if (ddcSync) begin
                modelPrevI   <= ddcSample.i;
                modelPrevQ   <= ddcSample.q;
                modelFmVideo <= crossProduct(modelPrevI, modelPrevQ, ddcSample.i, ddcSample.q);
                modelSwapI   <= modelControl[12] ? ddcSample.q : ddcSample.i;
                modelSwapQ   <= modelControl[12] ? ddcSample.i : ddcSample.q;
            end
            modelFmSync <= ddcSync;
            if (modelFmSync) begin
                modelLatched    <= modelFmVideo;
                modelLatchedAbs <= sampleWidth'(magnitudeOf(modelFmVideo));
                modelAvg        <= weightedAverage(modelLatched, modelAvg, modelLock[15:0]);
                modelAbsAvg     <= weightedAverage(modelLatchedAbs, modelAbsAvg,
                                                   modelLock[15:0]);
                if (modelAbsAvg > `ABS_FREQ_LIMIT)
                    modelHfo <= 1'b1;
                else if (magnitudeOf(modelAvg) > longint'(modelLock[31:16]))
                    modelHfo <= !carrierLock;
                else
                    modelHfo <= 1'b0;
            end
            modelDac0 <= channelSource(modelControl[3:0], modelAvg);
            modelDac1 <= channelSource(modelControl[7:4], modelAbsAvg);
            modelDac2 <= channelSource(modelControl[11:8], modelAvg);
        end
    end

    task automatic reportMismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("CHECK FAILED %s %s: expected 0x%0h, actual 0x%0h", testName, what,
                 expected, actual);
    endtask

    task automatic reportProblem(input string what);
        errorCount++;
        $display("ERROR in %s: %s", testName, what);
    endtask

    resetOutputsLow: assert property (@(posedge clk)
        $fell(reset) |-> !(dac0.sync || dac1.sync || dac2.sync || highFreqOffset))
        else reportProblem("a DAC sync or highFreqOffset is high right after reset");
    readbackCheck: assert property (@(posedge clk) disable iff (reset) dout == expectedDout)
        else reportMismatch("register readback", $sampled(expectedDout), $sampled(dout));
    offsetCheck: assert property (@(posedge clk) disable iff (reset) highFreqOffset == modelHfo)
        else reportMismatch("highFreqOffset", $sampled(modelHfo), $sampled(highFreqOffset));
    dac0SyncCheck: assert property (@(posedge clk) disable iff (reset)
        dac0.sync == modelDac0[sampleWidth])
        else reportMismatch("dac0 sync", $sampled(modelDac0[sampleWidth]), $sampled(dac0.sync));
    dac0DataCheck: assert property (@(posedge clk) disable iff (reset)
        modelDac0[sampleWidth] |-> dac0.data == modelDac0[sampleWidth-1:0])
        else reportMismatch("dac0 data", $sampled(modelDac0[sampleWidth-1:0]),
                            $sampled(dac0.data));
    dac1SyncCheck: assert property (@(posedge clk) disable iff (reset)
        dac1.sync == modelDac1[sampleWidth])
        else reportMismatch("dac1 sync", $sampled(modelDac1[sampleWidth]), $sampled(dac1.sync));
    dac1DataCheck: assert property (@(posedge clk) disable iff (reset)
        modelDac1[sampleWidth] |-> dac1.data == modelDac1[sampleWidth-1:0])
        else reportMismatch("dac1 data", $sampled(modelDac1[sampleWidth-1:0]),
                            $sampled(dac1.data));
    dac2SyncCheck: assert property (@(posedge clk) disable iff (reset)
        dac2.sync == modelDac2[sampleWidth])
        else reportMismatch("dac2 sync", $sampled(modelDac2[sampleWidth]), $sampled(dac2.sync));
    dac2DataCheck: assert property (@(posedge clk) disable iff (reset)
        modelDac2[sampleWidth] |-> dac2.data == modelDac2[sampleWidth-1:0])
        else reportMismatch("dac2 data", $sampled(modelDac2[sampleWidth-1:0]),
                            $sampled(dac2.data));

    task automatic drawRandom(output logic [31:0] value);
        rngState = xorshift(rngState);
        value    = rngState;
    endtask

    // address stays put afterwards so the readback check keeps watching it
    task automatic writeRegister(input logic [`BUS_ADDR_WIDTH-1:0] address,
                                 input logic [31:0] data, input logic [3:0] strobes);
        @(posedge clk);
        addr                 <= address;
        din                  <= data;
        {wr3, wr2, wr1, wr0} <= strobes;
        @(posedge clk);
        {wr3, wr2, wr1, wr0} <= 4'b0000;
    endtask

    task automatic readRegister(input logic [`BUS_ADDR_WIDTH-1:0] address, input int hold);
        @(posedge clk);
        addr <= address;
        repeat (hold) @(posedge clk);
    endtask

    // about three strobes in four, full-scale random I and Q
    task automatic driveRandomSamples(input int cycles, input bit randomLock);
        logic [31:0] first;
        logic [31:0] second;
        for (int n = 0; n < cycles; n++) begin
            drawRandom(first);
            drawRandom(second);
            @(posedge clk);
            ddcSync   <= first[31] | first[30];
            ddcSample <= '{i: first[sampleWidth-1:0], q: second[sampleWidth-1:0]};
            if (randomLock) carrierLock <= second[31];
        end
        @(posedge clk);
        ddcSync <= 1'b0;
    endtask

    // quarter-turn rotation, so every step gives the same video of amplitude^2 >> 17
    task automatic drivePhasor(input int amplitude, input bit reverse, input int cycles);
        logic signed [sampleWidth-1:0] pos;
        logic signed [sampleWidth-1:0] neg;
        pos = amplitude;
        neg = -amplitude;
        for (int n = 0; n < cycles; n++) begin
            @(posedge clk);
            ddcSync <= 1'b1;
            case (n % 4)
                0:       ddcSample <= '{i: pos, q: '0};
                1:       ddcSample <= '{i: '0, q: reverse ? neg : pos};
                2:       ddcSample <= '{i: neg, q: '0};
                default: ddcSample <= '{i: '0, q: reverse ? pos : neg};
            endcase
        end
        @(posedge clk);
        ddcSync <= 1'b0;
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = errorCount;
    endtask

    task automatic finishTest();
        repeat (4) @(posedge clk);
        testsRun++;
        if (errorCount != testErrors) begin
            testsFailed++;
            $display("test %s: failed, %0d errors", testName, errorCount - testErrors);
        end else begin
            $display("test %s: ok", testName);
        end
    endtask

    initial begin
        reset       = 1'b1;
        addr        = '0;
        din         = '0;
        wr0         = 1'b0;
        wr1         = 1'b0;
        wr2         = 1'b0;
        wr3         = 1'b0;
        ddcSync     = 1'b0;
        ddcSample   = '0;
        carrierLock = 1'b0;

        startTest("resetState");
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        readRegister(regAddress(`REG_CONTROL), 2);
        readRegister(regAddress(`REG_LOCK), 2);
        readRegister(regAddress(`REG_STATUS), 2);
        readRegister(12'hFFC, 2);
        finishTest();

        startTest("registerAccess");
        writeRegister(regAddress(`REG_CONTROL), 32'h1234_5678, 4'b1111);
        writeRegister(regAddress(`REG_CONTROL), 32'hAABB_CCDD, 4'b0101);
        writeRegister(regAddress(`REG_LOCK), 32'hDEAD_BEEF, 4'b1000);
        writeRegister(regAddress(`REG_LOCK), 32'h0102_0304, 4'b0010);
        writeRegister(regAddress(`REG_STATUS), 32'hFFFF_FFFF, 4'b1111);
        writeRegister(12'h3F0, 32'hFFFF_FFFF, 4'b1111);
        readRegister(regAddress(`REG_CONTROL), 2);
        readRegister(regAddress(`REG_LOCK), 2);
        readRegister(regAddress(2'd3), 2);
        readRegister(regAddress(`REG_STATUS), 2);
        carrierLock <= 1'b1;
        repeat (3) @(posedge clk);
        carrierLock <= 1'b0;
        finishTest();

        startTest("fmDiscriminator");
        writeRegister(regAddress(`REG_LOCK), {16'h3000, 16'h4000}, 4'b1111);
        writeRegister(regAddress(`REG_CONTROL), 32'h0000_0132, 4'b1111);
        readRegister(regAddress(`REG_STATUS), 1);
        driveRandomSamples(randomCycles, 1'b1);
        finishTest();

        startTest("falseLock");
        carrierLock <= 1'b0;
        writeRegister(regAddress(`REG_LOCK), {16'h4000, 16'h8000}, 4'b1111);
        writeRegister(regAddress(`REG_CONTROL), 32'h0000_0233, 4'b1111);
        readRegister(regAddress(`REG_STATUS), 1);
        // video 0x8000 sits between the threshold and the absolute limit
        drivePhasor(65536, 1'b0, phaseCycles);
        carrierLock <= 1'b1;
        drivePhasor(65536, 1'b0, phaseCycles);
        // video near 0x1AD27 is above the absolute limit
        drivePhasor(120000, 1'b0, phaseCycles);
        carrierLock <= 1'b0;
        drivePhasor(120000, 1'b0, phaseCycles);
        drivePhasor(65536, 1'b1, phaseCycles);
        finishTest();

        startTest("iqSwap");
        writeRegister(regAddress(`REG_CONTROL), 32'h0000_0F10, 4'b1111);
        driveRandomSamples(swapCycles, 1'b0);
        writeRegister(regAddress(`REG_CONTROL), 32'h0000_1F10, 4'b1111);
        driveRandomSamples(swapCycles, 1'b0);
        finishTest();

        $display("tests run %0d, tests failed %0d, check failures %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(totalCycles * clkPeriod);
        $display("watchdog expired: tests did not finish within %0d cycles", totalCycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/demodBackEnd.sv
`include "demod_cfg.svh"
`default_nettype none

module demodBackEnd (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic [`BUS_ADDR_WIDTH-1:0] addr,
    input  wire logic [`BUS_DATA_WIDTH-1:0] din,
    input  wire logic                       wr0,
    input  wire logic                       wr1,
    input  wire logic                       wr2,
    input  wire logic                       wr3,
    input  wire logic                       ddcSync,
    input  wire demodPkg::iqSample          ddcSample,
    input  wire logic                       carrierLock,
    output logic      [`BUS_DATA_WIDTH-1:0] dout,
    output logic                            highFreqOffset,
    output demodPkg::dacChannel             dac0,
    output demodPkg::dacChannel             dac1,
    output demodPkg::dacChannel             dac2
);

    demodPkg::demodControl           control;
    demodPkg::freqAverage            average;
    logic                            fmSync;
    logic signed [`SAMPLE_WIDTH-1:0] fmVideo;

    demodRegs regs (
        .clk            (clk),
        .reset          (reset),
        .addr           (addr),
        .din            (din),
        .wr0            (wr0),
        .wr1            (wr1),
        .wr2            (wr2),
        .wr3            (wr3),
        .highFreqOffset (highFreqOffset),
        .carrierLock    (carrierLock),
        .dout           (dout),
        .control        (control)
    );

    fmDiscriminator discriminator (
        .clk       (clk),
        .reset     (reset),
        .ddcSync   (ddcSync),
        .ddcSample (ddcSample),
        .fmSync    (fmSync),
        .fmVideo   (fmVideo)
    );

    // frequency estimate here is the FM video
    falseLockDetector lockDetector (
        .clk            (clk),
        .reset          (reset),
        .fmSync         (fmSync),
        .fmVideo        (fmVideo),
        .carrierLock    (carrierLock),
        .control        (control),
        .average        (average),
        .highFreqOffset (highFreqOffset)
    );

    dacMux monitor (
        .clk       (clk),
        .reset     (reset),
        .ddcSync   (ddcSync),
        .ddcSample (ddcSample),
        .fmSync    (fmSync),
        .fmVideo   (fmVideo),
        .average   (average),
        .control   (control),
        .dac0      (dac0),
        .dac1      (dac1),
        .dac2      (dac2)
    );

endmodule

`default_nettype wire

// File: verilog/dacMux.sv
`include "demod_cfg.svh"
`default_nettype none

module dacMux (
    input  wire logic                            clk,
    input  wire logic                            reset,
    input  wire logic                            ddcSync,
    input  wire demodPkg::iqSample               ddcSample,
    input  wire logic                            fmSync,
    input  wire logic signed [`SAMPLE_WIDTH-1:0] fmVideo,
    input  wire demodPkg::freqAverage            average,
    input  wire demodPkg::demodControl           control,
    output demodPkg::dacChannel                  dac0,
    output demodPkg::dacChannel                  dac1,
    output demodPkg::dacChannel                  dac2
);

    demodPkg::iqSample swapReg;

    // one source set shared by all three monitor channels
    function automatic demodPkg::dacChannel selectChannel(
        input logic [`DAC_SEL_WIDTH-1:0] sel,
        input logic [`SAMPLE_WIDTH-1:0]  avgData
    );
        demodPkg::dacChannel channel;
        case (sel)
            `DAC_Q: begin
                channel.sync = ddcSync;
                channel.data = swapReg.q;
            end
            `DAC_FREQ: begin
                channel.sync = fmSync;
                channel.data = fmVideo;
            end
            `DAC_AVGFREQ: begin
                channel.sync = fmSync;
                channel.data = avgData;
            end
            default: begin
                channel.sync = ddcSync;
                channel.data = swapReg.i;
            end
        endcase
        return channel;
    endfunction

    // I/Q swap
    always_ff @(posedge clk) begin
        if (reset) begin
            swapReg <= '0;
        end else if (ddcSync) begin
            if (control.iqSwap) begin
                swapReg.i <= ddcSample.q;
                swapReg.q <= ddcSample.i;
            end else begin
                swapReg <= ddcSample;
            end
        end
    end

    // channel 1 shows the absolute average in place of the average
    always_ff @(posedge clk) begin
        if (reset) begin
            dac0 <= '0;
            dac1 <= '0;
            dac2 <= '0;
        end else begin
            dac0 <= selectChannel(control.dac0Select, average.avg);
            dac1 <= selectChannel(control.dac1Select, average.absAvg);
            dac2 <= selectChannel(control.dac2Select, average.avg);
        end
    end

    noSyncInReset: assert property (
        @(posedge clk)
        reset |=> !(dac0.sync || dac1.sync || dac2.sync)
    );

endmodule

`default_nettype wire

// File: verilog/falseLockDetector.sv
`include "demod_cfg.svh"
`default_nettype none

module falseLockDetector (
    input  wire logic                            clk,
    input  wire logic                            reset,
    input  wire logic                            fmSync,
    input  wire logic signed [`SAMPLE_WIDTH-1:0] fmVideo,
    input  wire logic                            carrierLock,
    input  wire demodPkg::demodControl           control,
    output demodPkg::freqAverage                 average,
    output logic                                 highFreqOffset
);

    localparam int sampleWidth  = `SAMPLE_WIDTH;
    localparam int productWidth = 2 * sampleWidth + 3;
    // 1.0 in the Q17 weight format
    localparam logic signed [sampleWidth:0] unityWeight = 1 << `FRAC_BITS;

    function automatic logic [sampleWidth-1:0] magnitude(
        input logic signed [sampleWidth-1:0] value
    );
        logic [sampleWidth-1:0] negated;
        negated = ~value + 1'b1;
        return value[sampleWidth-1] ? negated : value;
    endfunction

    logic signed [sampleWidth-1:0]  freqSample;
    logic        [sampleWidth-1:0]  absFreqSample;
    logic signed [sampleWidth:0]    alphaWeight;
    logic signed [sampleWidth:0]    oneMinusWeight;
    logic signed [productWidth-1:0] newFreqTerm;
    logic signed [productWidth-1:0] oldFreqTerm;
    logic signed [productWidth-1:0] newAbsTerm;
    logic signed [productWidth-1:0] oldAbsTerm;
    logic signed [productWidth-1:0] freqSum;
    logic signed [productWidth-1:0] absSum;
    logic        [sampleWidth-1:0]  absAverage;

    // register alpha is shifted left 2 into Q17, kept non-negative
    assign alphaWeight    = {1'b0, control.falseLockAlpha, 2'b00};
    assign oneMinusWeight = unityWeight - alphaWeight;

    // frequency average
    assign newFreqTerm = freqSample * alphaWeight;
    assign oldFreqTerm = $signed(average.avg) * oneMinusWeight;
    assign freqSum     = (newFreqTerm >>> `FRAC_BITS) + (oldFreqTerm >>> `FRAC_BITS);

    // absolute frequency average, magnitudes padded to positive
    assign newAbsTerm = $signed({1'b0, absFreqSample}) * alphaWeight;
    assign oldAbsTerm = $signed({1'b0, average.absAvg}) * oneMinusWeight;
    assign absSum     = (newAbsTerm >>> `FRAC_BITS) + (oldAbsTerm >>> `FRAC_BITS);

    assign absAverage = magnitude(average.avg);

    always_ff @(posedge clk) begin
        if (reset) begin
            freqSample     <= '0;
            absFreqSample  <= '0;
            average        <= '0;
            highFreqOffset <= 1'b0;
        end else if (fmSync) begin
            freqSample     <= fmVideo;
            absFreqSample  <= magnitude(fmVideo);
            average.avg    <= freqSum[sampleWidth-1:0];
            average.absAvg <= absSum[sampleWidth-1:0];
            // a locked loop can sit off frequency only if it is a false lock
            if (average.absAvg > `ABS_FREQ_LIMIT) begin
                highFreqOffset <= 1'b1;
            end else if (absAverage > {2'b00, control.falseLockThreshold}) begin
                highFreqOffset <= !carrierLock;
            end else begin
                highFreqOffset <= 1'b0;
            end
        end
    end

    offsetOnlyOnSync: assert property (
        @(posedge clk) disable iff (reset)
        $changed(highFreqOffset) |-> $past(fmSync)
    );

endmodule

`default_nettype wire

// File: verilog/fmDiscriminator.sv
`include "demod_cfg.svh"
`default_nettype none

module fmDiscriminator (
    input  wire logic                            clk,
    input  wire logic                            reset,
    input  wire logic                            ddcSync,
    input  wire demodPkg::iqSample               ddcSample,
    output logic                                 fmSync,
    output logic signed [`SAMPLE_WIDTH-1:0]      fmVideo
);

    localparam int sampleWidth  = `SAMPLE_WIDTH;
    // one guard bit so the difference of two full products cannot wrap
    localparam int productWidth = 2 * sampleWidth + 1;

    demodPkg::iqSample               prevSample;
    logic signed [productWidth-1:0]  crossIQ;
    logic signed [productWidth-1:0]  crossQI;
    logic signed [productWidth-1:0]  crossDiff;
    logic signed [productWidth-1:0]  scaledDiff;

    // iPrev*qNow - qPrev*iNow is proportional to the phase step
    assign crossIQ    = $signed(prevSample.i) * $signed(ddcSample.q);
    assign crossQI    = $signed(prevSample.q) * $signed(ddcSample.i);
    assign crossDiff  = crossIQ - crossQI;
    assign scaledDiff = crossDiff >>> `FRAC_BITS;

    always_ff @(posedge clk) begin
        if (reset) begin
            prevSample <= '0;
            fmVideo    <= '0;
        end else if (ddcSync) begin
            prevSample <= ddcSample;
            fmVideo    <= scaledDiff[sampleWidth-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fmSync <= 1'b0;
        end else begin
            fmSync <= ddcSync;
        end
    end

    fmSyncFollowsDdc: assert property (
        @(posedge clk) disable iff (reset)
        fmSync |-> $past(ddcSync)
    );

endmodule

`default_nettype wire

// File: verilog/demodRegs.sv
`include "demod_cfg.svh"
`default_nettype none

module demodRegs (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic [`BUS_ADDR_WIDTH-1:0] addr,
    input  wire logic [`BUS_DATA_WIDTH-1:0] din,
    input  wire logic                       wr0,
    input  wire logic                       wr1,
    input  wire logic                       wr2,
    input  wire logic                       wr3,
    input  wire logic                       highFreqOffset,
    input  wire logic                       carrierLock,
    output logic      [`BUS_DATA_WIDTH-1:0] dout,
    output demodPkg::demodControl           control
);

    logic                                  inSpace;
    logic [`OFFSET_MSB-`OFFSET_LSB:0]      offset;
    logic                                  selControl;
    logic                                  selLock;
    logic                                  selStatus;
    logic [`BUS_DATA_WIDTH/8-1:0]          byteWrite;
    demodPkg::regWord                      writeWord;
    demodPkg::regWord                      controlReg;
    demodPkg::regWord                      lockReg;
    logic [`BUS_DATA_WIDTH-1:0]            statusWord;

    // address decode
    assign inSpace    = addr[`BUS_ADDR_WIDTH-1:`SPACE_LSB] == `DEMOD_SPACE;
    assign offset     = addr[`OFFSET_MSB:`OFFSET_LSB];
    assign selControl = inSpace && (offset == `REG_CONTROL);
    assign selLock    = inSpace && (offset == `REG_LOCK);
    assign selStatus  = inSpace && (offset == `REG_STATUS);

    assign byteWrite = {wr3, wr2, wr1, wr0};
    assign writeWord = din;

    // byte lane writes, status is read only
    always_ff @(posedge clk) begin
        if (reset) begin
            controlReg <= '0;
            lockReg    <= '0;
        end else begin
            for (int lane = 0; lane < `BUS_DATA_WIDTH / 8; lane++) begin
                if (byteWrite[lane] && selControl) begin
                    controlReg.lanes[lane] <= writeWord.lanes[lane];
                end
                if (byteWrite[lane] && selLock) begin
                    lockReg.lanes[lane] <= writeWord.lanes[lane];
                end
            end
        end
    end

    always_comb begin
        statusWord                   = '0;
        statusWord[`STATUS_HFO_BIT]  = highFreqOffset;
        statusWord[`STATUS_LOCK_BIT] = carrierLock;
    end

    // readback, zero outside the block and on unused offsets
    always_comb begin
        dout = '0;
        if (selControl) begin
            dout = controlReg;
        end else if (selLock) begin
            dout = lockReg;
        end else if (selStatus) begin
            dout = statusWord;
        end
    end

    // field view of the stored words
    assign control.dac0Select         = controlReg.control.dac0Select;
    assign control.dac1Select         = controlReg.control.dac1Select;
    assign control.dac2Select         = controlReg.control.dac2Select;
    assign control.iqSwap             = controlReg.control.iqSwap;
    assign control.falseLockAlpha     = lockReg.lock.falseLockAlpha;
    assign control.falseLockThreshold = lockReg.lock.falseLockThreshold;

    selectOneHot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({selControl, selLock, selStatus})
    );

endmodule

`default_nettype wire

// File: verilog/demodPkg.sv
`include "demod_cfg.svh"
`default_nettype none

package demodPkg;

    // one complex baseband sample
    typedef struct packed {
        logic signed [`SAMPLE_WIDTH-1:0] i;
        logic signed [`SAMPLE_WIDTH-1:0] q;
    } iqSample;

    // absolute average is a magnitude, so unsigned
    typedef struct packed {
        logic signed [`SAMPLE_WIDTH-1:0] avg;
        logic        [`SAMPLE_WIDTH-1:0] absAvg;
    } freqAverage;

    typedef struct packed {
        logic                     sync;
        logic [`SAMPLE_WIDTH-1:0] data;
    } dacChannel;

    // decoded configuration seen by the datapath
    typedef struct packed {
        logic [`DAC_SEL_WIDTH-1:0]    dac0Select;
        logic [`DAC_SEL_WIDTH-1:0]    dac1Select;
        logic [`DAC_SEL_WIDTH-1:0]    dac2Select;
        logic                         iqSwap;
        logic [`LOCK_FIELD_WIDTH-1:0] falseLockAlpha;
        logic [`LOCK_FIELD_WIDTH-1:0] falseLockThreshold;
    } demodControl;

    // layout of the control word, selects in the low bits
    typedef struct packed {
        logic [`BUS_DATA_WIDTH-3*`DAC_SEL_WIDTH-2:0] reserved;
        logic                                        iqSwap;
        logic [`DAC_SEL_WIDTH-1:0]                   dac2Select;
        logic [`DAC_SEL_WIDTH-1:0]                   dac1Select;
        logic [`DAC_SEL_WIDTH-1:0]                   dac0Select;
    } controlFields;

    // alpha in the low half, threshold in the high half
    typedef struct packed {
        logic [`LOCK_FIELD_WIDTH-1:0] falseLockThreshold;
        logic [`LOCK_FIELD_WIDTH-1:0] falseLockAlpha;
    } lockFields;

    typedef union packed {
        logic [`BUS_DATA_WIDTH/8-1:0][7:0] lanes;
        controlFields                      control;
        lockFields                         lock;
    } regWord;

endpackage

`default_nettype wire

// File: verilog/demod_cfg.svh
`ifndef DEMOD_CFG_SVH
`define DEMOD_CFG_SVH

// sample and DAC word format, signed fixed point
`define SAMPLE_WIDTH        18
`define FRAC_BITS           17

// processor bus
`define BUS_ADDR_WIDTH      12
`define BUS_DATA_WIDTH      32

// addr[11:4] selects the block, addr[3:2] the word inside it
`define SPACE_LSB           4
`define OFFSET_MSB          3
`define OFFSET_LSB          2
`define DEMOD_SPACE         8'h10

// word offsets
`define REG_CONTROL         2'd0
`define REG_LOCK            2'd1
`define REG_STATUS          2'd2

// status word bits
`define STATUS_HFO_BIT      0
`define STATUS_LOCK_BIT     1

// register field widths
`define DAC_SEL_WIDTH       4
`define LOCK_FIELD_WIDTH    16

// DAC select codes, anything else falls back to DAC_I
`define DAC_I               4'd0
`define DAC_Q               4'd1
`define DAC_FREQ            4'd2
`define DAC_AVGFREQ         4'd3

// above this absolute average the offset is always flagged
`define ABS_FREQ_LIMIT      18'h10000

`endif
